/* hw/ndscore_cfg.svh */
`ifndef NDSCORE_CFG_SVH
`define NDSCORE_CFG_SVH

// Datapath and register file
`define NDS_DATA_W    32
`define NDS_INST_W    32
`define NDS_REG_AW    5
`define NDS_NUM_REGS  32
`define NDS_SHAMT_W   5

// Instruction fields
`define NDS_OPC_HI    30
`define NDS_OPC_LO    25
`define NDS_RT_HI     24
`define NDS_RT_LO     20
`define NDS_RA_HI     19
`define NDS_RA_LO     15
`define NDS_RB_HI     14
`define NDS_RB_LO     10
`define NDS_SUB_HI    4
`define NDS_SUB_LO    0

// Immediate top bits, both start at bit 0
`define NDS_IMM15_HI  14
`define NDS_IMM20_HI  19

`endif

/* hw/ndscore_pkg.sv */
`default_nettype none

`include "ndscore_cfg.svh"

package ndscore_pkg;

   // Major opcode, bits 30..25
   typedef enum logic [5:0] {
      OPC_ALU1 = 6'b100000,
      OPC_ADDI = 6'b101000,
      OPC_ORI  = 6'b101100,
      OPC_XORI = 6'b101011,
      OPC_MOVI = 6'b100010
   } nds_opcode_e;

   // ALU group sub-opcode, bits 4..0
   typedef enum logic [4:0] {
      SUB_ADD   = 5'b00000,
      SUB_SUB   = 5'b00001,
      SUB_AND   = 5'b00010,
      SUB_XOR   = 5'b00011,
      SUB_OR    = 5'b00100,
      SUB_SLLI  = 5'b01000,
      SUB_SRLI  = 5'b01001,
      SUB_ROTRI = 5'b01011
   } nds_sub_e;

   typedef enum logic [3:0] {
      ALU_PASS,   // Result is operand b
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLL,
      ALU_SRL,
      ALU_ROTR
   } nds_alu_op_e;

   // Decode to execute
   typedef struct packed {
      logic                    valid;
      nds_alu_op_e             alu_op;
      logic [`NDS_DATA_W-1:0]  op_a;
      logic [`NDS_DATA_W-1:0]  op_b;
      logic [`NDS_REG_AW-1:0]  dest;
      logic                    wr_en;
   } nds_dec_t;

   // Execute to write-back, also the bypass source
   typedef struct packed {
      logic                    wr_en;
      logic [`NDS_REG_AW-1:0]  dest;
      logic [`NDS_DATA_W-1:0]  data;
   } nds_wb_t;

endpackage

`default_nettype wire

/* hw/ndscore_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ndscore_cfg.svh"

module ndscore_decoder (
   input  wire                        clk,
   input  wire                        rst_n_i,
   input  wire                        inst_valid_i,
   input  wire  [`NDS_INST_W-1:0]     inst_i,
   output logic [`NDS_REG_AW-1:0]     rs1_addr_o,
   output logic [`NDS_REG_AW-1:0]     rs2_addr_o,
   input  wire  [`NDS_DATA_W-1:0]     rs1_data_i,
   input  wire  [`NDS_DATA_W-1:0]     rs2_data_i,
   input  ndscore_pkg::nds_wb_t       bypass_i,
   output ndscore_pkg::nds_dec_t      dec_o
);

   ndscore_pkg::nds_opcode_e  opcode;
   ndscore_pkg::nds_sub_e     sub_op;
   ndscore_pkg::nds_alu_op_e  alu_op;
   logic                      writes;
   logic                      use_imm;
   logic [`NDS_SHAMT_W-1:0]   shamt;
   logic [`NDS_DATA_W-1:0]    imm;
   logic [`NDS_DATA_W-1:0]    imm_se15;
   logic [`NDS_DATA_W-1:0]    imm_ze15;
   logic [`NDS_DATA_W-1:0]    imm_se20;
   logic [`NDS_DATA_W-1:0]    imm_shamt;
   logic [`NDS_DATA_W-1:0]    rs1_val;
   logic [`NDS_DATA_W-1:0]    rs2_val;

   logic                      valid_q;
   logic                      wr_en_q;
   ndscore_pkg::nds_alu_op_e  alu_op_q;
   logic [`NDS_DATA_W-1:0]    op_a_q;
   logic [`NDS_DATA_W-1:0]    op_b_q;
   logic [`NDS_REG_AW-1:0]    dest_q;

   assign opcode = ndscore_pkg::nds_opcode_e'(inst_i[`NDS_OPC_HI:`NDS_OPC_LO]);
   assign sub_op = ndscore_pkg::nds_sub_e'(inst_i[`NDS_SUB_HI:`NDS_SUB_LO]);
   assign shamt  = inst_i[`NDS_RB_HI:`NDS_RB_LO];

   assign rs1_addr_o = inst_i[`NDS_RA_HI:`NDS_RA_LO];
   assign rs2_addr_o = inst_i[`NDS_RB_HI:`NDS_RB_LO];

   assign imm_se15  = {{(`NDS_DATA_W-`NDS_IMM15_HI-1){inst_i[`NDS_IMM15_HI]}},
                       inst_i[`NDS_IMM15_HI:0]};
   assign imm_ze15  = {{(`NDS_DATA_W-`NDS_IMM15_HI-1){1'b0}}, inst_i[`NDS_IMM15_HI:0]};
   assign imm_se20  = {{(`NDS_DATA_W-`NDS_IMM20_HI-1){inst_i[`NDS_IMM20_HI]}},
                       inst_i[`NDS_IMM20_HI:0]};
   assign imm_shamt = {{(`NDS_DATA_W-`NDS_SHAMT_W){1'b0}}, shamt};

   always_comb begin
      alu_op  = ndscore_pkg::ALU_PASS;
      writes  = 1'b0;
      use_imm = 1'b0;
      imm     = '0;
      case (opcode)
         ndscore_pkg::OPC_ALU1: begin
            case (sub_op)
               ndscore_pkg::SUB_ADD: begin
                  alu_op = ndscore_pkg::ALU_ADD;
                  writes = 1'b1;
               end
               ndscore_pkg::SUB_SUB: begin
                  alu_op = ndscore_pkg::ALU_SUB;
                  writes = 1'b1;
               end
               ndscore_pkg::SUB_AND: begin
                  alu_op = ndscore_pkg::ALU_AND;
                  writes = 1'b1;
               end
               ndscore_pkg::SUB_OR: begin
                  alu_op = ndscore_pkg::ALU_OR;
                  writes = 1'b1;
               end
               ndscore_pkg::SUB_XOR: begin
                  alu_op = ndscore_pkg::ALU_XOR;
                  writes = 1'b1;
               end
               ndscore_pkg::SUB_SLLI: begin
                  alu_op  = ndscore_pkg::ALU_SLL;
                  writes  = 1'b1;
                  use_imm = 1'b1;
                  imm     = imm_shamt;
               end
               ndscore_pkg::SUB_SRLI: begin
                  alu_op  = ndscore_pkg::ALU_SRL;
                  writes  = (shamt != '0);   // SRLI by 0 is NOP
                  use_imm = 1'b1;
                  imm     = imm_shamt;
               end
               ndscore_pkg::SUB_ROTRI: begin
                  alu_op  = ndscore_pkg::ALU_ROTR;
                  writes  = 1'b1;
                  use_imm = 1'b1;
                  imm     = imm_shamt;
               end
               default: begin
                  writes = 1'b0;
               end
            endcase
         end
         ndscore_pkg::OPC_ADDI: begin
            alu_op  = ndscore_pkg::ALU_ADD;
            writes  = 1'b1;
            use_imm = 1'b1;
            imm     = imm_se15;
         end
         ndscore_pkg::OPC_ORI: begin
            alu_op  = ndscore_pkg::ALU_OR;
            writes  = 1'b1;
            use_imm = 1'b1;
            imm     = imm_ze15;
         end
         ndscore_pkg::OPC_XORI: begin
            alu_op  = ndscore_pkg::ALU_XOR;
            writes  = 1'b1;
            use_imm = 1'b1;
            imm     = imm_ze15;
         end
         ndscore_pkg::OPC_MOVI: begin
            writes  = 1'b1;         // PASS of the immediate
            use_imm = 1'b1;
            imm     = imm_se20;
         end
         default: begin
            writes = 1'b0;
         end
      endcase
   end

   // Forward the result now in execute
   assign rs1_val = (bypass_i.wr_en && bypass_i.dest == rs1_addr_o) ? bypass_i.data
                                                                    : rs1_data_i;
   assign rs2_val = (bypass_i.wr_en && bypass_i.dest == rs2_addr_o) ? bypass_i.data
                                                                    : rs2_data_i;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
         wr_en_q <= 1'b0;
      end else begin
         valid_q <= inst_valid_i;
         wr_en_q <= inst_valid_i && writes;
      end
   end

   always_ff @(posedge clk) begin
      if (inst_valid_i) begin
         alu_op_q <= alu_op;
         op_a_q   <= rs1_val;
         op_b_q   <= use_imm ? imm : rs2_val;
         dest_q   <= inst_i[`NDS_RT_HI:`NDS_RT_LO];
      end
   end

   assign dec_o = '{valid:  valid_q,
                    alu_op: alu_op_q,
                    op_a:   op_a_q,
                    op_b:   op_b_q,
                    dest:   dest_q,
                    wr_en:  wr_en_q};

   a_dest_known: assert property (@(posedge clk) disable iff (!rst_n_i)
      dec_o.valid |-> !$isunknown(dec_o.dest))
      else $error("Decoded packet with unknown destination");

endmodule

`default_nettype wire

/* hw/ndscore_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ndscore_cfg.svh"

module ndscore_alu (
   input  ndscore_pkg::nds_dec_t  dec_i,
   output ndscore_pkg::nds_wb_t   wb_o
);

   logic [`NDS_SHAMT_W-1:0]   shamt;
   logic [2*`NDS_DATA_W-1:0]  rot_ext;
   logic [`NDS_DATA_W-1:0]    result;

   assign shamt   = dec_i.op_b[`NDS_SHAMT_W-1:0];
   assign rot_ext = {dec_i.op_a, dec_i.op_a} >> shamt;   // Low half is the rotate

   always_comb begin
      case (dec_i.alu_op)
         ndscore_pkg::ALU_ADD: begin
            result = dec_i.op_a + dec_i.op_b;
         end
         ndscore_pkg::ALU_SUB: begin
            result = dec_i.op_a - dec_i.op_b;
         end
         ndscore_pkg::ALU_AND: begin
            result = dec_i.op_a & dec_i.op_b;
         end
         ndscore_pkg::ALU_OR: begin
            result = dec_i.op_a | dec_i.op_b;
         end
         ndscore_pkg::ALU_XOR: begin
            result = dec_i.op_a ^ dec_i.op_b;
         end
         ndscore_pkg::ALU_SLL: begin
            result = dec_i.op_a << shamt;
         end
         ndscore_pkg::ALU_SRL: begin
            result = dec_i.op_a >> shamt;
         end
         ndscore_pkg::ALU_ROTR: begin
            result = rot_ext[`NDS_DATA_W-1:0];
         end
         default: begin
            result = dec_i.op_b;   // PASS, MOVI
         end
      endcase
   end

   assign wb_o = '{wr_en: dec_i.valid & dec_i.wr_en,
                   dest:  dec_i.dest,
                   data:  result};

   // Decoder only sets wr_en together with valid
   a_wr_en_valid: assert final (!dec_i.wr_en || dec_i.valid)
      else $error("Write enable set in a packet that is not valid");

endmodule

`default_nettype wire

/* hw/ndscore_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ndscore_cfg.svh"

module ndscore_regfile (
   input  wire                        clk,
   input  wire                        rst_n_i,
   input  wire  [`NDS_REG_AW-1:0]     rs1_addr_i,
   input  wire  [`NDS_REG_AW-1:0]     rs2_addr_i,
   output logic [`NDS_DATA_W-1:0]     rs1_data_o,
   output logic [`NDS_DATA_W-1:0]     rs2_data_o,
   input  ndscore_pkg::nds_wb_t       wb_i,
   output logic                       result_valid_o,
   output logic [`NDS_REG_AW-1:0]     result_dest_o,
   output logic [`NDS_DATA_W-1:0]     result_data_o
);

   logic [`NDS_DATA_W-1:0] regs [`NDS_NUM_REGS];

   // Combinational reads
   assign rs1_data_o = regs[rs1_addr_i];
   assign rs2_data_o = regs[rs2_addr_i];

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < `NDS_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_i.wr_en) begin
         regs[wb_i.dest] <= wb_i.data;
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         result_valid_o <= 1'b0;
      end else begin
         result_valid_o <= wb_i.wr_en;   // One-cycle pulse per write
      end
   end

   always_ff @(posedge clk) begin
      if (wb_i.wr_en) begin
         result_dest_o <= wb_i.dest;
         result_data_o <= wb_i.data;
      end
   end

   a_pulse_follows_write: assert property (@(posedge clk) disable iff (!rst_n_i)
      wb_i.wr_en |=> result_valid_o)
      else $error("Result pulse missing after a write");

   a_no_stray_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
      !wb_i.wr_en |=> !result_valid_o)
      else $error("Result pulse without a write");

endmodule

`default_nettype wire

/* hw/ndscore_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ndscore_cfg.svh"

module ndscore_top (
   input  wire                        clk,
   input  wire                        rst_n_i,
   input  wire                        inst_valid_i,
   input  wire  [`NDS_INST_W-1:0]     inst_i,
   output logic                       result_valid_o,
   output logic [`NDS_REG_AW-1:0]     result_dest_o,
   output logic [`NDS_DATA_W-1:0]     result_data_o
);

   logic [`NDS_REG_AW-1:0]  rs1_addr;
   logic [`NDS_REG_AW-1:0]  rs2_addr;
   logic [`NDS_DATA_W-1:0]  rs1_data;
   logic [`NDS_DATA_W-1:0]  rs2_data;
   ndscore_pkg::nds_dec_t   dec;
   ndscore_pkg::nds_wb_t    wb;   // Also the decoder bypass

   ndscore_decoder i_decoder (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .inst_valid_i (inst_valid_i),
      .inst_i       (inst_i),
      .rs1_addr_o   (rs1_addr),
      .rs2_addr_o   (rs2_addr),
      .rs1_data_i   (rs1_data),
      .rs2_data_i   (rs2_data),
      .bypass_i     (wb),
      .dec_o        (dec)
   );

   ndscore_alu i_alu (
      .dec_i (dec),
      .wb_o  (wb)
   );

   ndscore_regfile i_regfile (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .rs1_addr_i     (rs1_addr),
      .rs2_addr_i     (rs2_addr),
      .rs1_data_o     (rs1_data),
      .rs2_data_o     (rs2_data),
      .wb_i           (wb),
      .result_valid_o (result_valid_o),
      .result_dest_o  (result_dest_o),
      .result_data_o  (result_data_o)
   );

endmodule

`default_nettype wire

/* tb/tb_ndscore.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ndscore_cfg.svh"

module tb_ndscore;

   localparam logic [5:0] OPC_ALU1 = 6'b100000;
   localparam logic [5:0] OPC_ADDI = 6'b101000;
   localparam logic [5:0] OPC_ORI  = 6'b101100;
   localparam logic [5:0] OPC_XORI = 6'b101011;
   localparam logic [5:0] OPC_MOVI = 6'b100010;
   localparam logic [4:0] RR_ADD   = 5'b00000;
   localparam logic [4:0] RR_SUB   = 5'b00001;
   localparam logic [4:0] RR_AND   = 5'b00010;
   localparam logic [4:0] RR_XOR   = 5'b00011;
   localparam logic [4:0] RR_OR    = 5'b00100;
   localparam logic [4:0] RR_SLLI  = 5'b01000;
   localparam logic [4:0] RR_SRLI  = 5'b01001;
   localparam logic [4:0] RR_ROTRI = 5'b01011;

   localparam int N_LOAD = 32, N_RR = 40, N_IMM = 12, N_SHIFT = 15, N_CHAIN = 40;
   localparam int DRAIN = 3;
   localparam int SLOTS = N_LOAD + N_RR + N_IMM + N_SHIFT + N_CHAIN + 5 * DRAIN + 6;
   localparam int TIMEOUT_NS = (SLOTS + 20) * 8;

   typedef struct packed {
      logic                    valid;
      logic [`NDS_REG_AW-1:0]  dest;
      logic [`NDS_DATA_W-1:0]  data;
   } expect_t;

   logic                    clk;
   logic                    rst_n_i;
   logic                    inst_valid_i;
   logic [`NDS_INST_W-1:0]  inst_i;
   logic                    result_valid_o;
   logic [`NDS_REG_AW-1:0]  result_dest_o;
   logic [`NDS_DATA_W-1:0]  result_data_o;

   logic [`NDS_DATA_W-1:0]  model_regs [`NDS_NUM_REGS];
   expect_t                 next_exp;
   expect_t                 exp_d1;
   expect_t                 exp_d2;   // Lines up with the result pulse
   integer                  seed = 41;
   int                      err_cnt, err_before, n_tests, n_issued, n_expected;
   logic [4:0]              prev1, prev2, rt, ra, rb, t, d;
   int                      sel;

   ndscore_top i_dut (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .inst_valid_i   (inst_valid_i),
      .inst_i         (inst_i),
      .result_valid_o (result_valid_o),
      .result_dest_o  (result_dest_o),
      .result_data_o  (result_data_o)
   );

   always #4 clk = ~clk;

   always @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         exp_d1 <= '0;
         exp_d2 <= '0;
      end else begin
         exp_d1 <= next_exp;
         exp_d2 <= exp_d1;
      end
   end

   a_pulse_present: assert property (@(posedge clk) disable iff (!rst_n_i)
      exp_d2.valid |-> result_valid_o)
      else begin
         err_cnt++;
         $display("Result pulse for r%0d did not appear at %0t ns", $sampled(exp_d2.dest), $time);
      end

   a_no_extra_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
      !exp_d2.valid |-> !result_valid_o)
      else begin
         err_cnt++;
         $display("A result pulse appeared at %0t ns where none was expected", $time);
      end

   a_result_value: assert property (@(posedge clk) disable iff (!rst_n_i)
      exp_d2.valid |-> (result_dest_o == exp_d2.dest && result_data_o == exp_d2.data))
      else begin
         err_cnt++;
         $display("Error at %0t ns: result r%0d = %h, expected r%0d = %h", $time,
                  $sampled(result_dest_o), $sampled(result_data_o),
                  $sampled(exp_d2.dest), $sampled(exp_d2.data));
      end

   function automatic logic [31:0] rr_word(input logic [4:0] sub, dst, src_a, src_b);
      return {1'b0, OPC_ALU1, dst, src_a, src_b, 5'b0, sub};
   endfunction

   function automatic logic [31:0] imm_word(input logic [5:0] opc, input logic [4:0] dst,
                                            input logic [4:0] src_a, input logic [14:0] imm);
      return {1'b0, opc, dst, src_a, imm};
   endfunction

   function automatic logic [31:0] movi_word(input logic [4:0] dst, input logic [19:0] imm);
      return {1'b0, OPC_MOVI, dst, imm};
   endfunction

   function automatic logic [4:0] pick_reg();
      logic [31:0] r;
      r = $random(seed);
      return r[4:0];
   endfunction

   // Architectural effect of one instruction on the shadow registers
   task automatic predict(input logic [31:0] inst, output logic wr, output logic [31:0] val);
      logic [4:0]  sub, amt;
      logic [31:0] a, b;
      sub = inst[4:0];
      amt = inst[14:10];
      a   = model_regs[inst[19:15]];
      b   = model_regs[inst[14:10]];
      wr  = 1'b1;
      val = '0;
      case (inst[30:25])
         OPC_ALU1: begin
            case (sub)
               RR_ADD:   val = a + b;
               RR_SUB:   val = a - b;
               RR_AND:   val = a & b;
               RR_OR:    val = a | b;
               RR_XOR:   val = a ^ b;
               RR_SLLI:  val = a << amt;
               RR_SRLI: begin
                  val = a >> amt;
                  wr  = (amt != 0);   // NOP form
               end
               RR_ROTRI: val = (a >> amt) | (a << (32 - amt));
               default:  wr = 1'b0;
            endcase
         end
         OPC_ADDI: val = a + {{17{inst[14]}}, inst[14:0]};
         OPC_ORI:  val = a | {17'b0, inst[14:0]};
         OPC_XORI: val = a ^ {17'b0, inst[14:0]};
         OPC_MOVI: val = {{12{inst[19]}}, inst[19:0]};
         default:  wr = 1'b0;
      endcase
   endtask

   task automatic issue(input logic [31:0] inst);
      logic        wr;
      logic [31:0] val;
      predict(inst, wr, val);
      @(posedge clk);
      #1;
      inst_valid_i = 1'b1;
      inst_i       = inst;
      next_exp     = '{valid: wr, dest: inst[24:20], data: val};
      if (wr) begin
         model_regs[inst[24:20]] = val;
         n_expected++;
      end
      n_issued++;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
         inst_valid_i = 1'b0;
         inst_i       = '0;
         next_exp     = '0;
      end
   endtask

   task automatic close_test(input string name);
      idle_cycles(DRAIN);   // Last result checked by now
      n_tests++;
      if (err_cnt == err_before)
         $display("Test %s finished: ok", name);
      else
         $display("Test %s finished: %0d errors", name, err_cnt - err_before);
      err_before = err_cnt;
   endtask

   initial begin
      #(TIMEOUT_NS);
      $display("Watchdog expired, the tests did not finish in time");
      $display("** FAIL **");
      $finish;
   end

   initial begin
      clk          = 1'b0;
      rst_n_i      = 1'b0;
      inst_valid_i = 1'b0;
      inst_i       = '0;
      next_exp     = '0;
      for (int i = 0; i < `NDS_NUM_REGS; i++) model_regs[i] = '0;
      repeat (2) @(posedge clk);
      #1 rst_n_i = 1'b1;

      idle_cycles(4);   // No pulse before the first write
      for (int i = 0; i < N_LOAD; i++)
         issue(movi_word(i[4:0], {i[0], 19'($random(seed))}));
      close_test("reset_and_load");

      for (int i = 0; i < N_RR; i++) begin
         case (i % 5)
            0: issue(rr_word(RR_ADD, pick_reg(), pick_reg(), pick_reg()));
            1: issue(rr_word(RR_SUB, pick_reg(), pick_reg(), pick_reg()));
            2: issue(rr_word(RR_AND, pick_reg(), pick_reg(), pick_reg()));
            3: issue(rr_word(RR_OR, pick_reg(), pick_reg(), pick_reg()));
            default: issue(rr_word(RR_XOR, pick_reg(), pick_reg(), pick_reg()));
         endcase
      end
      close_test("register_ops");

      for (int i = 0; i < N_IMM / 3; i++) begin
         issue(imm_word(OPC_ADDI, pick_reg(), pick_reg(), 15'($random(seed)) | 15'h4000));
         issue(imm_word(OPC_ORI, pick_reg(), pick_reg(), 15'($random(seed)) | 15'h4000));
         issue(imm_word(OPC_XORI, pick_reg(), pick_reg(), 15'($random(seed)) | 15'h4000));
      end
      close_test("immediate_ops");

      issue(rr_word(RR_SLLI, pick_reg(), pick_reg(), 5'd31));
      issue(rr_word(RR_SLLI, pick_reg(), pick_reg(), pick_reg()));
      issue(rr_word(RR_SRLI, pick_reg(), pick_reg(), 5'd31));
      issue(rr_word(RR_SRLI, pick_reg(), pick_reg(), pick_reg() | 5'd1));
      issue(rr_word(RR_ROTRI, pick_reg(), pick_reg(), 5'd31));
      issue(rr_word(RR_ROTRI, pick_reg(), pick_reg(), pick_reg()));
      issue(rr_word(RR_ROTRI, pick_reg(), pick_reg(), 5'd0));
      t = pick_reg();
      d = t + 5'd1;
      // Each non-writing form aimed at t, then t read back through an ADD
      issue(rr_word(RR_SRLI, t, pick_reg(), 5'd0));
      issue(rr_word(RR_ADD, d, t, t));
      issue(imm_word(6'b111111, t, pick_reg(), 15'h1234));
      issue(rr_word(RR_ADD, d, t, t));
      issue(rr_word(5'b00101, t, pick_reg(), pick_reg()));
      issue(rr_word(RR_ADD, d, t, t));
      issue(rr_word(5'b11111, t, pick_reg(), pick_reg()));
      issue(rr_word(RR_ADD, d, t, t));
      close_test("shifts_and_nop");

      prev1 = pick_reg();
      prev2 = pick_reg();
      for (int i = 0; i < N_CHAIN; i++) begin
         sel = {$random(seed)} % 4;
         rt  = pick_reg();
         // Mode 3 puts the previous destination on the second source
         ra  = (sel == 1) ? pick_reg() : (sel == 3) ? prev2 : prev1;
         rb  = (sel == 0) ? pick_reg() : (sel == 3) ? prev1 : prev2;
         case ({$random(seed)} % 8)
            0: issue(rr_word(RR_ADD, rt, ra, rb));
            1: issue(rr_word(RR_SUB, rt, ra, rb));
            2: issue(rr_word(RR_AND, rt, ra, rb));
            3: issue(rr_word(RR_OR, rt, ra, rb));
            4: issue(rr_word(RR_XOR, rt, ra, rb));
            5: issue(imm_word(OPC_ADDI, rt, ra, 15'($random(seed))));
            6: issue(rr_word(RR_SLLI, rt, ra, pick_reg()));
            default: issue(rr_word(RR_ROTRI, rt, ra, pick_reg()));
         endcase
         prev2 = prev1;
         prev1 = rt;
      end
      close_test("dependency_chains");

      $display("Summary: %0d tests, %0d instructions, %0d results checked, %0d errors",
               n_tests, n_issued, n_expected, err_cnt);
      if (err_cnt == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hw
hw/ndscore_pkg.sv
hw/ndscore_decoder.sv
hw/ndscore_alu.sv
hw/ndscore_regfile.sv
hw/ndscore_top.sv
tb/tb_ndscore.sv
